// ==== sources.f ====
uart_pkg.sv
cmd_pkg.sv
baud_gen.sv
uart_rx.sv
uart_tx.sv
cmd_decode.sv
cmd_execute.sv
cmd_result.sv
uart_cmd_top.sv
tb_uart_cmd.sv

// ==== Bender.yml ====
package:
  name: uart_cmd

sources:
  - uart_pkg.sv
  - cmd_pkg.sv
  - baud_gen.sv
  - uart_rx.sv
  - uart_tx.sv
  - cmd_decode.sv
  - cmd_execute.sv
  - cmd_result.sv
  - uart_cmd_top.sv
  - target: simulation
    files:
      - tb_uart_cmd.sv

// ==== tb_uart_cmd.sv ====
`timescale 1ns/1ps

module tb_uart_cmd;
  import uart_pkg::*;
  import cmd_pkg::*;

  localparam int clk_period     = 40;
  localparam int bit_clks       = sample_div * oversample;
  localparam int idle_clks      = 300;
  localparam int num_cmds       = 32;
  // one command frame, the response wait, the response frame and tx_done fit in 2000 clk
  localparam int timeout_cycles = num_cmds * 2000 + idle_clks + 2000;

  logic clk;
  logic reset;
  logic parity_enable;
  logic rx_pin;
  logic tx_pin;
  logic tx_busy;
  logic tx_done;

  logic [reg_w-1:0] model_regs [num_regs];
  int               value_errors;
  int               proto_errors;
  int               checks_run;
  int               frames_seen;
  int               done_count;
  int               cycle_count;
  logic             done_prev;

  uart_cmd_top i_dut (
    .clk, .reset, .parity_enable, .rx_pin, .tx_pin, .tx_busy, .tx_done
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // ====================================================================
  // line checks that hold for the whole run
  // ====================================================================
  a_idle_line: assert property (@(posedge clk) disable iff (reset)
    !tx_busy |-> tx_pin)
    else begin
      proto_errors++;
      $display("tx_pin went low while tx_busy was low at %0t", $time);
    end

  a_done_length: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_done) |-> ##bit_clks $fell(tx_done))
    else begin
      proto_errors++;
      $display("tx_done did not last exactly one bit period at %0t", $time);
    end

  a_done_after_frame: assert property (@(posedge clk) disable iff (reset)
    $rose(tx_done) |-> $fell(tx_busy))
    else begin
      proto_errors++;
      $display("tx_done rose without the end of a frame at %0t", $time);
    end

  always @(posedge clk) begin
    done_prev <= tx_done;
    if (tx_done && !done_prev) begin
      done_count++;
    end
  end

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d clock cycles, the DUT stopped responding", cycle_count);
    $display("Testbench failed");
    $finish;
  end

  // command frame into rx_pin with LSB first
  task automatic drive_frame(input logic [7:0] data, input bit bad_parity,
                             input bit bad_stop);
    rx_pin <= 1'b0;
    repeat (bit_clks) @(posedge clk);
    for (int i = 0; i < data_bits; i++) begin
      rx_pin <= data[i];
      repeat (bit_clks) @(posedge clk);
    end
    if (parity_enable) begin
      rx_pin <= (~^data) ^ bad_parity;
      repeat (bit_clks) @(posedge clk);
    end
    rx_pin <= !bad_stop;
    repeat (bit_clks) @(posedge clk);
    rx_pin <= 1'b1;
  endtask

  // samples tx_pin at each bit middle counted from the falling edge
  task automatic receive_frame(output logic [7:0] data);
    logic par_bit;
    logic stop_bit;
    do @(posedge clk); while (tx_pin);
    repeat (bit_clks / 2 - 1) @(posedge clk);
    assert (!tx_pin && tx_busy) else begin
      proto_errors++;
      $display("response start bit not held low with tx_busy at %0t", $time);
    end
    for (int i = 0; i < data_bits; i++) begin
      repeat (bit_clks) @(posedge clk);
      data[i] = tx_pin;
      assert (tx_busy) else begin
        proto_errors++;
        $display("tx_busy dropped inside a response frame at %0t", $time);
      end
    end
    if (parity_enable) begin
      repeat (bit_clks) @(posedge clk);
      par_bit = tx_pin;
      assert (par_bit == ~^data) else begin
        proto_errors++;
        $display("response parity bit is not odd parity at %0t", $time);
      end
    end
    repeat (bit_clks) @(posedge clk);
    stop_bit = tx_pin;
    assert (stop_bit && tx_busy) else begin
      proto_errors++;
      $display("response stop bit missing or tx_busy low at %0t", $time);
    end
    frames_seen++;
  endtask

  // register model updated as each command is predicted
  function automatic logic [7:0] predict_response(input opcode_e op,
                                                  input logic [1:0] addr,
                                                  input logic [3:0] imm, input bit bad);
    if (bad) begin
      return err_byte;
    end
    case (op)
      op_write_lo: model_regs[addr] = {model_regs[addr][7:4], imm};
      op_write_hi: model_regs[addr] = {imm, model_regs[addr][3:0]};
      op_add:      model_regs[addr] = model_regs[addr] + {4'h0, imm};
      default:     model_regs[addr] = model_regs[addr];
    endcase
    return model_regs[addr];
  endfunction

  task automatic run_command(input opcode_e op, input logic [1:0] addr,
                             input logic [3:0] imm, input bit bad_parity,
                             input bit bad_stop);
    logic [7:0] cmd_byte;
    logic [7:0] expected;
    logic [7:0] got;
    cmd_byte = {op, addr, imm};
    expected = predict_response(op, addr, imm, bad_parity || bad_stop);
    drive_frame(cmd_byte, bad_parity, bad_stop);
    receive_frame(got);
    checks_run++;
    assert (got == expected) else begin
      value_errors++;
      $display("ERR @%0t: command 0x%02h answered 0x%02h, expected 0x%02h",
               $time, cmd_byte, got, expected);
    end
    // next command only once the transmitter is back in idle
    do @(posedge clk); while (!tx_done);
    do @(posedge clk); while (tx_done);
  endtask

  // ====================================================================
  // stimulus
  // ====================================================================
  initial begin : stimulus
    int unsigned seed;
    seed          = $urandom(32'ha2bb);
    reset         = 1'b1;
    parity_enable = 1'b0;
    rx_pin        = 1'b1;
    value_errors  = 0;
    proto_errors  = 0;
    checks_run    = 0;
    frames_seen   = 0;
    done_count    = 0;
    done_prev     = 1'b0;
    for (int i = 0; i < num_regs; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    // quiet line until the first command
    repeat (idle_clks) begin
      @(posedge clk);
      assert (tx_pin && !tx_busy && !tx_done) else begin
        proto_errors++;
        $display("transmitter active before any command at %0t", $time);
      end
    end

    for (int r = 0; r < num_regs; r++) begin
      run_command(op_write_lo, 2'(r), 4'($urandom_range(15)), 1'b0, 1'b0);
      run_command(op_write_hi, 2'(r), 4'($urandom_range(15)), 1'b0, 1'b0);
      run_command(op_read, 2'(r), 4'($urandom_range(15)), 1'b0, 1'b0);
    end

    // reg 0 to 0xff first so the add has to wrap
    run_command(op_write_hi, 2'd0, 4'hf, 1'b0, 1'b0);
    run_command(op_write_lo, 2'd0, 4'hf, 1'b0, 1'b0);
    run_command(op_add, 2'd0, 4'($urandom_range(1, 15)), 1'b0, 1'b0);
    repeat (8) begin
      run_command(op_add, 2'($urandom_range(3)), 4'($urandom_range(15)), 1'b0, 1'b0);
    end

    parity_enable <= 1'b1;
    repeat (4) @(posedge clk);
    run_command(op_write_lo, 2'd1, 4'($urandom_range(15)), 1'b0, 1'b0);
    run_command(op_read, 2'd1, 4'h0, 1'b0, 1'b0);
    // rejected writes carry a nibble that differs from the register contents
    run_command(op_write_hi, 2'd1, ~model_regs[1][7:4], 1'b1, 1'b0);
    run_command(op_read, 2'd1, 4'h0, 1'b0, 1'b0);
    run_command(op_add, 2'd1, 4'($urandom_range(15)), 1'b0, 1'b0);

    // zero stop bit with and without parity
    run_command(op_add, 2'd2, 4'($urandom_range(1, 15)), 1'b0, 1'b1);
    run_command(op_read, 2'd2, 4'h0, 1'b0, 1'b0);
    parity_enable <= 1'b0;
    repeat (4) @(posedge clk);
    run_command(op_write_lo, 2'd3, ~model_regs[3][3:0], 1'b0, 1'b1);
    run_command(op_read, 2'd3, 4'h0, 1'b0, 1'b0);

    repeat (bit_clks) @(posedge clk);
    assert (done_count == frames_seen) else begin
      proto_errors++;
      $display("saw %0d tx_done pulses for %0d response frames", done_count, frames_seen);
    end

    $display("commands checked %0d, value errors %0d, protocol errors %0d",
             checks_run, value_errors, proto_errors);
    if (value_errors == 0 && proto_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== uart_cmd_top.sv ====
`timescale 1ns/1ps

module uart_cmd_top (
  input  logic clk,
  input  logic reset,
  input  logic parity_enable,
  input  logic rx_pin,
  output logic tx_pin,
  output logic tx_busy,
  output logic tx_done
);
  import uart_pkg::*;
  import cmd_pkg::*;

  logic         sample_tick;
  logic         bit_tick;
  logic         rx_valid;
  rx_frame_t    rx_frame;
  logic         cmd_valid;
  cmd_t         cmd;
  logic         res_valid;
  exec_result_t res;
  logic         send_request;
  logic [7:0]   tx_data;

  baud_gen u_baud_gen (
    .clk, .reset, .sample_tick, .bit_tick
  );

  // ====================================================================
  // receive side
  // ====================================================================
  uart_rx u_uart_rx (
    .clk, .reset, .sample_tick, .parity_enable, .rx_pin, .rx_valid, .rx_frame
  );

  cmd_decode u_cmd_decode (
    .clk, .reset, .rx_valid, .rx_frame, .cmd_valid, .cmd
  );

  cmd_execute u_cmd_execute (
    .clk, .reset, .cmd_valid, .cmd, .res_valid, .res
  );

  // ====================================================================
  // response side
  // ====================================================================
  cmd_result u_cmd_result (
    .clk, .reset, .res_valid, .res, .tx_busy, .send_request, .tx_data
  );

  uart_tx u_uart_tx (
    .clk, .reset, .bit_tick, .send_request, .tx_data, .parity_enable,
    .tx_pin, .tx_busy, .tx_done
  );

endmodule

// ==== cmd_result.sv ====
`timescale 1ns/1ps

module cmd_result (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  res_valid,
  input  cmd_pkg::exec_result_t res,
  input  logic                  tx_busy,
  output logic                  send_request,
  output logic [7:0]            tx_data
);
  import cmd_pkg::*;

  logic load;

  // single holding byte, a result arriving while one waits is lost
  assign load = res_valid && !send_request;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      send_request <= 1'b0;
    end else if (load) begin
      send_request <= 1'b1;
    end else if (send_request && tx_busy) begin
      // transmitter has taken the byte
      send_request <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      tx_data <= res.bad ? err_byte : res.value;
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (reset)
    res_valid |-> !send_request)
    else $error("result dropped, response byte still pending");

endmodule

// ==== cmd_execute.sv ====
`timescale 1ns/1ps

module cmd_execute (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_valid,
  input  cmd_pkg::cmd_t         cmd,
  output logic                  res_valid,
  output cmd_pkg::exec_result_t res
);
  import cmd_pkg::*;

  logic [reg_w-1:0] regs [num_regs];
  logic [reg_w-1:0] cur_value;
  logic [reg_w-1:0] new_value;

  always_comb begin
    cur_value = regs[cmd.addr];
    case (cmd.opcode)
      op_write_lo: new_value = {cur_value[reg_w-1:imm_w], cmd.imm};
      op_write_hi: new_value = {cmd.imm, cur_value[imm_w-1:0]};
      // wraps modulo 256
      op_add:      new_value = cur_value + {{(reg_w - imm_w){1'b0}}, cmd.imm};
      default:     new_value = cur_value;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      res_valid <= 1'b0;
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else begin
      res_valid <= cmd_valid;
      if (cmd_valid && !cmd.bad) begin
        regs[cmd.addr] <= new_value;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      res.value <= cmd.bad ? cur_value : new_value;
      res.bad   <= cmd.bad;
    end
  end

  a_res_follows: assert property (@(posedge clk) disable iff (reset)
    cmd_valid |=> res_valid)
    else $error("command without result");

endmodule

// ==== cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
  input  logic                clk,
  input  logic                reset,
  input  logic                rx_valid,
  input  uart_pkg::rx_frame_t rx_frame,
  output logic                cmd_valid,
  output cmd_pkg::cmd_t       cmd
);
  import uart_pkg::*;
  import cmd_pkg::*;

  logic frame_bad;

  assign frame_bad = rx_frame.frame_error | rx_frame.parity_error;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= rx_valid;
    end
  end

  // ====================================================================
  // field split
  // ====================================================================
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      cmd.opcode <= opcode_e'(rx_frame.data[data_bits-1 -: 2]);
      cmd.addr   <= rx_frame.data[imm_w +: addr_w];
      cmd.imm    <= rx_frame.data[imm_w-1:0];
      // a failed frame still travels down so it gets a response
      cmd.bad    <= frame_bad;
    end
  end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           bit_tick,
  input  logic                           send_request,
  input  logic [uart_pkg::data_bits-1:0] tx_data,
  input  logic                           parity_enable,
  output logic                           tx_pin,
  output logic                           tx_busy,
  output logic                           tx_done
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop,
    st_done
  } tx_state_e;

  tx_state_e            state, next_state;
  logic [bit_cnt_w-1:0] bit_idx, next_bit_idx;
  logic [data_bits-1:0] shift, next_shift;
  logic                 next_pin;
  logic                 next_busy;
  logic                 next_done;

  // everything advances on bit_tick only
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state   <= st_idle;
      bit_idx <= '0;
      tx_pin  <= 1'b1;
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
    end else if (bit_tick) begin
      state   <= next_state;
      bit_idx <= next_bit_idx;
      tx_pin  <= next_pin;
      tx_busy <= next_busy;
      tx_done <= next_done;
    end
  end

  always_ff @(posedge clk) begin
    if (bit_tick) begin
      shift <= next_shift;
    end
  end

  always_comb begin
    next_state   = state;
    next_bit_idx = bit_idx;
    next_shift   = shift;
    next_pin     = tx_pin;
    next_busy    = tx_busy;
    next_done    = tx_done;
    case (state)
      st_idle: begin
        next_pin  = 1'b1;
        next_busy = 1'b0;
        next_done = 1'b0;
        if (send_request) begin
          next_shift = tx_data;
          next_busy  = 1'b1;
          next_state = st_start;
        end
      end
      st_start: begin
        next_pin     = 1'b0;
        next_bit_idx = '0;
        next_state   = st_data;
      end
      st_data: begin
        next_pin     = shift[bit_idx];
        next_bit_idx = bit_idx + 1'b1;
        if (bit_idx == bit_cnt_w'(data_bits - 1)) begin
          next_bit_idx = '0;
          next_state   = parity_enable ? st_parity : st_stop;
        end
      end
      st_parity: begin
        next_pin   = ~^shift;
        next_state = st_stop;
      end
      st_stop: begin
        next_pin   = 1'b1;
        next_state = st_done;
      end
      st_done: begin
        next_pin   = 1'b1;
        next_busy  = 1'b0;
        next_done  = 1'b1;
        next_state = st_idle;
      end
      default: next_state = st_idle;
    endcase
  end

  a_idle_high: assert property (@(posedge clk) disable iff (reset)
    !tx_busy |-> tx_pin)
    else $error("tx_pin low outside a frame");

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
  input  logic                clk,
  input  logic                reset,
  input  logic                sample_tick,
  input  logic                parity_enable,
  input  logic                rx_pin,
  output logic                rx_valid,
  output uart_pkg::rx_frame_t rx_frame
);
  import uart_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop
  } rx_state_e;

  rx_state_e            state;
  logic [1:0]           sync;
  logic                 rx_bit;
  logic                 rx_prev;
  logic [os_cnt_w-1:0]  tick_cnt;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [data_bits-1:0] shift;
  logic                 parity_error;
  logic                 start_mid;
  logic                 bit_mid;

  assign rx_bit    = sync[1];
  // start bit is checked half a bit in, later bits a full bit apart
  assign start_mid = sample_tick && (tick_cnt == os_cnt_w'(oversample / 2 - 1));
  assign bit_mid   = sample_tick && (tick_cnt == os_cnt_w'(oversample - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sync <= 2'b11;
    end else begin
      sync <= {sync[0], rx_pin};
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      rx_prev  <= 1'b1;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (sample_tick) begin
        rx_prev  <= rx_bit;
        tick_cnt <= tick_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          // falling edge only, so a stuck-low line after a bad stop is ignored
          if (sample_tick && rx_prev && !rx_bit) begin
            state    <= st_start;
            tick_cnt <= '0;
          end
        end
        st_start: begin
          if (start_mid) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_bit ? st_idle : st_data;
          end
        end
        st_data: begin
          if (bit_mid) begin
            tick_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == bit_cnt_w'(data_bits - 1)) begin
              state <= parity_enable ? st_parity : st_stop;
            end
          end
        end
        st_parity: begin
          if (bit_mid) begin
            tick_cnt <= '0;
            state    <= st_stop;
          end
        end
        st_stop: begin
          if (bit_mid) begin
            state    <= st_idle;
            rx_valid <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data path, LSB first
  always_ff @(posedge clk) begin
    if (state == st_start && start_mid) begin
      parity_error <= 1'b0;
    end
    if (state == st_data && bit_mid) begin
      shift <= {rx_bit, shift[data_bits-1:1]};
    end
    if (state == st_parity && bit_mid) begin
      // odd parity: data plus parity bit hold an odd count of ones
      parity_error <= ~^{shift, rx_bit};
    end
    if (state == st_stop && bit_mid) begin
      rx_frame.data         <= shift;
      rx_frame.frame_error  <= ~rx_bit;
      rx_frame.parity_error <= parity_error;
    end
  end

endmodule

// ==== baud_gen.sv ====
`timescale 1ns/1ps

module baud_gen (
  input  logic clk,
  input  logic reset,
  output logic sample_tick,
  output logic bit_tick
);
  import uart_pkg::*;

  logic [sample_cnt_w-1:0] sample_cnt;
  logic [os_cnt_w-1:0]     os_cnt;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sample_cnt  <= '0;
      os_cnt      <= '0;
      sample_tick <= 1'b0;
      bit_tick    <= 1'b0;
    end else begin
      sample_tick <= 1'b0;
      bit_tick    <= 1'b0;
      if (sample_cnt == sample_cnt_w'(sample_div - 1)) begin
        sample_cnt  <= '0;
        sample_tick <= 1'b1;
        // every 16th sample tick is also a bit tick
        if (os_cnt == os_cnt_w'(oversample - 1)) begin
          os_cnt   <= '0;
          bit_tick <= 1'b1;
        end else begin
          os_cnt <= os_cnt + 1'b1;
        end
      end else begin
        sample_cnt <= sample_cnt + 1'b1;
      end
    end
  end

  a_bit_on_sample: assert property (@(posedge clk) disable iff (reset)
    bit_tick |-> sample_tick)
    else $error("bit_tick without sample_tick");

endmodule

// ==== cmd_pkg.sv ====
package cmd_pkg;

  localparam int num_regs = 4;
  localparam int reg_w    = 8;
  localparam int addr_w   = $clog2(num_regs);
  localparam int imm_w    = 4;

  // response byte for a frame that failed a check
  localparam logic [reg_w-1:0] err_byte = 8'he5;

  // ====================================================================
  // command byte layout
  //   bits 7..6  opcode
  //   bits 5..4  register number
  //   bits 3..0  immediate
  // ====================================================================
  typedef enum logic [1:0] {
    op_write_lo = 2'd0,
    op_write_hi = 2'd1,
    op_add      = 2'd2,
    op_read     = 2'd3
  } opcode_e;

  typedef struct packed {
    opcode_e           opcode;
    logic [addr_w-1:0] addr;
    logic [imm_w-1:0]  imm;
    logic              bad;
  } cmd_t;

  typedef struct packed {
    logic [reg_w-1:0] value;
    logic             bad;
  } exec_result_t;

endpackage

// ==== uart_pkg.sv ====
package uart_pkg;

  // ====================================================================
  // serial line settings
  // ====================================================================
  localparam int data_bits  = 8;
  // clk cycles per sample tick
  localparam int sample_div = 4;
  // sample ticks per bit, so one bit is 64 clk
  localparam int oversample = 16;

  // counter widths derived from the line settings
  localparam int sample_cnt_w = $clog2(sample_div);
  localparam int os_cnt_w     = $clog2(oversample);
  localparam int bit_cnt_w    = $clog2(data_bits);

  // one received character plus its check flags
  typedef struct packed {
    logic [data_bits-1:0] data;
    logic                 frame_error;
    logic                 parity_error;
  } rx_frame_t;

endpackage
